//--- verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   // ********************
   // Widths
   // ********************

   localparam int DATA_W   = 32;                // Load/store data word
   localparam int ECC_W    = 7;                 // Six Hamming bits plus overall parity
   localparam int DCCM_W   = DATA_W + ECC_W;    // Stored word with check bits
   localparam int OFFSET_W = 12;                // Signed immediate offset

   // ********************
   // Encodings
   // ********************

   // Access size of a load or store
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } lsu_size_e;

   // Fault reported on err_type
   typedef enum logic [1:0] {
      exc_none       = 2'd0,
      exc_access     = 2'd1,   // Address outside the DCCM window
      exc_misaligned = 2'd2,   // Half at odd address or word off a 4-byte boundary
      exc_ecc        = 2'd3    // Uncorrectable read data
   } lsu_exc_e;

endpackage

`default_nettype wire

//--- verilog/lsu_ecc.sv
`timescale 1ns/1ps
`default_nettype none

// SECDED (39,32) over Hamming positions 1..38 with check bits at powers of two
// Stored word is {overall parity, check[5:0], data[31:0]}
module lsu_ecc import lsu_pkg::*; (
   input  logic [DATA_W-1:0] store_data,
   input  logic [DCCM_W-1:0] dccm_rd_data,
   output logic [DCCM_W-1:0] dccm_wr_data,
   output logic [DATA_W-1:0] corr_data,
   output logic              single_err_dc2,
   output logic              double_err_dc2
);

   localparam int HAM_W  = ECC_W - 1;    // Hamming check bits
   localparam int CW_LEN = DCCM_W - 1;   // Codeword positions without overall parity

   // Place data bits on the non power-of-two positions
   function automatic logic [CW_LEN:1] spread(input logic [DATA_W-1:0] d);
      logic [CW_LEN:1] cw;
      int              j;
      cw = '0;
      j  = 0;
      for (int p = 1; p <= CW_LEN; p++) begin
         if ((p & (p - 1)) != 0) begin
            cw[p] = d[j];
            j++;
         end
      end
      return cw;
   endfunction

   function automatic logic [DATA_W-1:0] gather(input logic [CW_LEN:1] cw);
      logic [DATA_W-1:0] d;
      int                j;
      d = '0;
      j = 0;
      for (int p = 1; p <= CW_LEN; p++) begin
         if ((p & (p - 1)) != 0) begin
            d[j] = cw[p];
            j++;
         end
      end
      return d;
   endfunction

   // XOR of the positions of all set bits
   function automatic logic [HAM_W-1:0] syndrome(input logic [CW_LEN:1] cw);
      logic [HAM_W-1:0] s;
      s = '0;
      for (int p = 1; p <= CW_LEN; p++) begin
         if (cw[p]) begin
            s = s ^ HAM_W'(p);
         end
      end
      return s;
   endfunction

   logic [HAM_W-1:0]  wr_chk;
   logic [DATA_W-1:0] rd_word;
   logic [HAM_W-1:0]  rd_chk;
   logic [HAM_W-1:0]  syn;
   logic              par_err;
   logic [CW_LEN:1]   rd_cw;

   // ********************
   // Encode
   // ********************

   assign wr_chk       = syndrome(spread(store_data));
   assign dccm_wr_data = {^{store_data, wr_chk}, wr_chk, store_data};   // Even overall parity

   // ********************
   // Decode
   // ********************

   assign rd_word = dccm_rd_data[DATA_W-1:0];
   assign rd_chk  = dccm_rd_data[DCCM_W-2:DATA_W];
   assign syn     = syndrome(spread(rd_word)) ^ rd_chk;
   assign par_err = ^dccm_rd_data;

   assign single_err_dc2 = par_err;                     // Includes a flipped parity bit
   assign double_err_dc2 = (syn != '0) & ~par_err;

   always_comb begin
      rd_cw = spread(rd_word);
      if (par_err && (syn != '0) && (int'(syn) <= CW_LEN)) begin
         rd_cw[syn] = ~rd_cw[syn];   // Check bit positions drop out in gather
      end
      corr_data = gather(rd_cw);
   end

endmodule

`default_nettype wire

//--- verilog/lsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen import lsu_pkg::*; #(
   parameter logic [31:0] DCCM_BASE = 32'hf004_0000,
   parameter int          DCCM_AW   = 10
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                lsu_valid,
   input  logic [31:0]         rs1,
   input  logic [OFFSET_W-1:0] offset,
   input  lsu_size_e           lsu_size,
   input  logic                lsu_unsign,
   output logic [DCCM_AW-1:0]  dccm_addr,
   output logic                access_fault_dc1,
   output logic                misaligned_dc1,
   output logic [31:0]         addr_dc2,
   output lsu_size_e           size_dc2,
   output logic                unsign_dc2
);

   logic [31:0] addr_d;
   logic [31:0] dccm_off;
   logic        in_dccm;
   logic        misaligned;
   logic [31:0] addr_dc1;
   lsu_size_e   size_dc1;
   logic        unsign_dc1;

   assign addr_d   = rs1 + {{(32-OFFSET_W){offset[OFFSET_W-1]}}, offset};
   assign dccm_off = addr_d - DCCM_BASE;                  // Wraps high below the base
   assign in_dccm  = (dccm_off >> (DCCM_AW + 2)) == '0;

   always_comb begin
      case (lsu_size)
         size_byte: misaligned = 1'b0;
         size_half: misaligned = addr_d[0];
         default:   misaligned = |addr_d[1:0];
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         access_fault_dc1 <= 1'b0;
         misaligned_dc1   <= 1'b0;
      end else begin
         access_fault_dc1 <= lsu_valid & ~in_dccm;
         misaligned_dc1   <= lsu_valid & misaligned;
      end
   end

   // Address and attributes follow the op through dc1 and dc2
   always_ff @(posedge clk) begin
      if (lsu_valid) begin
         addr_dc1   <= addr_d;
         size_dc1   <= lsu_size;
         unsign_dc1 <= lsu_unsign;
      end
      addr_dc2   <= addr_dc1;
      size_dc2   <= size_dc1;
      unsign_dc2 <= unsign_dc1;
   end

   // Base is aligned to the DCCM size, so the low bits index the word
   assign dccm_addr = addr_dc1[DCCM_AW+1:2];

endmodule

`default_nettype wire

//--- verilog/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [DATA_W-1:0] corr_data,
   input  logic [1:0]        addr_dc2,
   input  lsu_size_e         size_dc2,
   input  logic              unsign_dc2,
   input  logic              ld_done_dc2,
   output logic              result_valid,
   output logic [DATA_W-1:0] result
);

   logic [DATA_W-1:0] shifted;
   logic [DATA_W-1:0] aligned;

   assign shifted = corr_data >> {addr_dc2, 3'b000};   // Addressed byte to bit 0

   always_comb begin
      case (size_dc2)
         size_byte: aligned = {{(DATA_W-8){~unsign_dc2 & shifted[7]}}, shifted[7:0]};
         size_half: aligned = {{(DATA_W-16){~unsign_dc2 & shifted[15]}}, shifted[15:0]};
         default:   aligned = shifted;
      endcase
   end

   // ********************
   // dc3 result
   // ********************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_valid <= 1'b0;
      end else begin
         result_valid <= ld_done_dc2;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_done_dc2) begin
         result <= aligned;
      end
   end

endmodule

`default_nettype wire

//--- verilog/lsu_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl import lsu_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        lsu_valid,
   input  logic        lsu_load,
   input  logic        lsu_store,
   input  logic        flush,
   input  logic        access_fault_dc1,
   input  logic        misaligned_dc1,
   input  logic        single_err_dc2,
   input  logic        double_err_dc2,
   input  logic [31:0] addr_dc2,
   output logic        dccm_rden,
   output logic        dccm_wren,
   output logic        ld_done_dc2,
   output logic        single_ecc_incr,
   output logic        err_valid,
   output logic        err_store,
   output lsu_exc_e    err_type,
   output logic [31:0] err_addr,
   output logic        lsu_idle
);

   logic     valid_dc1, load_dc1, store_dc1;
   logic     valid_dc2, load_dc2, store_dc2;
   logic     access_fault_dc2, misaligned_dc2;
   logic     fault_dc1;
   logic     live_dc2;
   logic     err_dc2;
   lsu_exc_e exc_dc2;

   // ********************
   // Stage flags
   // ********************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_dc1        <= 1'b0;
         load_dc1         <= 1'b0;
         store_dc1        <= 1'b0;
         valid_dc2        <= 1'b0;
         load_dc2         <= 1'b0;
         store_dc2        <= 1'b0;
         access_fault_dc2 <= 1'b0;
         misaligned_dc2   <= 1'b0;
      end else begin
         valid_dc1        <= lsu_valid & (lsu_load | lsu_store);
         load_dc1         <= lsu_load;
         store_dc1        <= lsu_store & ~lsu_load;   // Load wins if both are set
         valid_dc2        <= valid_dc1 & ~flush;      // Flush kills dc1
         load_dc2         <= load_dc1;
         store_dc2        <= store_dc1;
         access_fault_dc2 <= access_fault_dc1;
         misaligned_dc2   <= misaligned_dc1;
      end
   end

   // Memory access only for a clean, unflushed op in dc1
   assign fault_dc1 = access_fault_dc1 | misaligned_dc1;
   assign dccm_rden = valid_dc1 & load_dc1 & ~fault_dc1 & ~flush;
   assign dccm_wren = valid_dc1 & store_dc1 & ~fault_dc1 & ~flush;

   // ********************
   // dc2 outcome
   // ********************

   assign live_dc2 = valid_dc2 & ~flush;

   // Address faults take priority over the ECC check
   always_comb begin
      if (access_fault_dc2) begin
         exc_dc2 = exc_access;
      end else if (misaligned_dc2) begin
         exc_dc2 = exc_misaligned;
      end else if (load_dc2 && double_err_dc2) begin
         exc_dc2 = exc_ecc;
      end else begin
         exc_dc2 = exc_none;
      end
   end

   assign ld_done_dc2 = live_dc2 & load_dc2 & (exc_dc2 == exc_none);
   assign err_dc2     = live_dc2 & (exc_dc2 != exc_none);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         err_valid       <= 1'b0;
         single_ecc_incr <= 1'b0;
      end else begin
         err_valid       <= err_dc2;
         single_ecc_incr <= ld_done_dc2 & single_err_dc2;   // Corrected load only
      end
   end

   // Error details hold until the next fault
   always_ff @(posedge clk) begin
      if (err_dc2) begin
         err_store <= store_dc2;
         err_type  <= exc_dc2;
         err_addr  <= addr_dc2;
      end
   end

   assign lsu_idle = ~(valid_dc1 | valid_dc2);

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

// Pipeline: request -> dc1 (memory access) -> dc2 (check, align) -> dc3 (result)
// Store data is taken during dc1, the cycle in which dccm_wren is driven
module lsu_top import lsu_pkg::*; #(
   parameter logic [31:0] DCCM_BASE = 32'hf004_0000,
   parameter int          DCCM_AW   = 10
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                lsu_valid,
   input  logic                lsu_load,
   input  logic                lsu_store,
   input  lsu_size_e           lsu_size,
   input  logic                lsu_unsign,
   input  logic [31:0]         rs1,
   input  logic [OFFSET_W-1:0] offset,
   input  logic [DATA_W-1:0]   store_data,
   input  logic                flush,
   input  logic [DCCM_W-1:0]   dccm_rd_data,
   output logic                dccm_rden,
   output logic                dccm_wren,
   output logic [DCCM_AW-1:0]  dccm_addr,
   output logic [DCCM_W-1:0]   dccm_wr_data,
   output logic                result_valid,
   output logic [DATA_W-1:0]   result,
   output logic                single_ecc_incr,
   output logic                err_valid,
   output logic                err_store,
   output lsu_exc_e            err_type,
   output logic [31:0]         err_addr,
   output logic                lsu_idle
);

   logic              access_fault_dc1;
   logic              misaligned_dc1;
   logic [31:0]       addr_dc2;
   lsu_size_e         size_dc2;
   logic              unsign_dc2;
   logic [DATA_W-1:0] corr_data;
   logic              single_err_dc2;
   logic              double_err_dc2;
   logic              ld_done_dc2;

   lsu_ctl u_lsu_ctl (
      .clk              (clk),
      .arst_n           (arst_n),
      .lsu_valid        (lsu_valid),
      .lsu_load         (lsu_load),
      .lsu_store        (lsu_store),
      .flush            (flush),
      .access_fault_dc1 (access_fault_dc1),
      .misaligned_dc1   (misaligned_dc1),
      .single_err_dc2   (single_err_dc2),
      .double_err_dc2   (double_err_dc2),
      .addr_dc2         (addr_dc2),
      .dccm_rden        (dccm_rden),
      .dccm_wren        (dccm_wren),
      .ld_done_dc2      (ld_done_dc2),
      .single_ecc_incr  (single_ecc_incr),
      .err_valid        (err_valid),
      .err_store        (err_store),
      .err_type         (err_type),
      .err_addr         (err_addr),
      .lsu_idle         (lsu_idle)
   );

   lsu_addr_gen #(
      .DCCM_BASE (DCCM_BASE),
      .DCCM_AW   (DCCM_AW)
   ) u_lsu_addr_gen (
      .clk              (clk),
      .arst_n           (arst_n),
      .lsu_valid        (lsu_valid),
      .rs1              (rs1),
      .offset           (offset),
      .lsu_size         (lsu_size),
      .lsu_unsign       (lsu_unsign),
      .dccm_addr        (dccm_addr),
      .access_fault_dc1 (access_fault_dc1),
      .misaligned_dc1   (misaligned_dc1),
      .addr_dc2         (addr_dc2),
      .size_dc2         (size_dc2),
      .unsign_dc2       (unsign_dc2)
   );

   lsu_ecc u_lsu_ecc (
      .store_data     (store_data),
      .dccm_rd_data   (dccm_rd_data),
      .dccm_wr_data   (dccm_wr_data),
      .corr_data      (corr_data),
      .single_err_dc2 (single_err_dc2),
      .double_err_dc2 (double_err_dc2)
   );

   lsu_load_align u_lsu_load_align (
      .clk          (clk),
      .arst_n       (arst_n),
      .corr_data    (corr_data),
      .addr_dc2     (addr_dc2[1:0]),   // Byte offset only
      .size_dc2     (size_dc2),
      .unsign_dc2   (unsign_dc2),
      .ld_done_dc2  (ld_done_dc2),
      .result_valid (result_valid),
      .result       (result)
   );

endmodule

`default_nettype wire

//--- verif/lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
   input logic clk,
   input logic arst_n,
   input logic flush,
   input logic dccm_rden,
   input logic dccm_wren,
   input logic result_valid,
   input logic err_valid,
   input logic single_ecc_incr
);

   // ********************
   // Memory port
   // ********************

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(dccm_rden && dccm_wren))
      else $error("DCCM read and write enables high in the same cycle");

   // A flushed op never reaches the memory
   a_flush_no_access: assert property (@(posedge clk) disable iff (!arst_n)
      flush |-> (!dccm_rden && !dccm_wren))
      else $error("DCCM enable high while flush is set");

   // ********************
   // Result side
   // ********************

   a_result_err_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(result_valid && err_valid))
      else $error("result_valid and err_valid high together");

   a_ecc_incr_result: assert property (@(posedge clk) disable iff (!arst_n)
      single_ecc_incr |-> result_valid)   // Count only on a delivered load
      else $error("single_ecc_incr without result_valid");

endmodule

bind lsu_top lsu_checker u_lsu_checker (.*);

`default_nettype wire

//--- verif/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

   localparam logic [31:0] DCCM_BASE  = 32'hf004_0000;
   localparam int          DCCM_AW    = 10;
   localparam int          MAX_CYCLES = 400;   // Tests take about 215 cycles

   logic                clk = 1'b0;
   logic                arst_n;
   logic                lsu_valid;
   logic                lsu_load;
   logic                lsu_store;
   lsu_size_e           lsu_size;
   logic                lsu_unsign;
   logic [31:0]         rs1;
   logic [OFFSET_W-1:0] offset;
   logic [DATA_W-1:0]   store_data;
   logic                flush;
   logic [DCCM_W-1:0]   dccm_rd_data = '0;
   logic                dccm_rden;
   logic                dccm_wren;
   logic [DCCM_AW-1:0]  dccm_addr;
   logic [DCCM_W-1:0]   dccm_wr_data;
   logic                result_valid;
   logic [DATA_W-1:0]   result;
   logic                single_ecc_incr;
   logic                err_valid;
   logic                err_store;
   lsu_exc_e            err_type;
   logic [31:0]         err_addr;
   logic                lsu_idle;

   logic [DCCM_W-1:0]   mem    [0:(1<<DCCM_AW)-1];
   logic [DATA_W-1:0]   shadow [0:(1<<DCCM_AW)-1];   // Data last stored per word
   logic                flip_en;
   logic [DCCM_AW-1:0]  flip_idx;
   logic [DCCM_W-1:0]   flip_mask;
   int                  cycle_cnt = 0;

   always #20 clk = ~clk;

   lsu_top #(
      .DCCM_BASE (DCCM_BASE),
      .DCCM_AW   (DCCM_AW)
   ) u_lsu_top (
      .clk             (clk),
      .arst_n          (arst_n),
      .lsu_valid       (lsu_valid),
      .lsu_load        (lsu_load),
      .lsu_store       (lsu_store),
      .lsu_size        (lsu_size),
      .lsu_unsign      (lsu_unsign),
      .rs1             (rs1),
      .offset          (offset),
      .store_data      (store_data),
      .flush           (flush),
      .dccm_rd_data    (dccm_rd_data),
      .dccm_rden       (dccm_rden),
      .dccm_wren       (dccm_wren),
      .dccm_addr       (dccm_addr),
      .dccm_wr_data    (dccm_wr_data),
      .result_valid    (result_valid),
      .result          (result),
      .single_ecc_incr (single_ecc_incr),
      .err_valid       (err_valid),
      .err_store       (err_store),
      .err_type        (err_type),
      .err_addr        (err_addr),
      .lsu_idle        (lsu_idle)
   );

   // ********************
   // DCCM model
   // ********************

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dccm_rd_data <= '0;
      end else begin
         if (dccm_wren) mem[dccm_addr] <= dccm_wr_data;
         if (flip_en) mem[flip_idx] <= mem[flip_idx] ^ flip_mask;   // Fault injection
         if (dccm_rden) dccm_rd_data <= mem[dccm_addr];
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   // ********************
   // Checks
   // ********************

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_exc(input string name, input lsu_exc_e got, input lsu_exc_e exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] eff_addr(input logic [31:0] base,
                                            input logic [OFFSET_W-1:0] off);
      return base + 32'($signed(off));
   endfunction

   function automatic logic [DCCM_AW-1:0] word_idx(input logic [31:0] addr);
      logic [31:0] rel;
      rel = addr - DCCM_BASE;
      return rel[DCCM_AW+1:2];
   endfunction

   // Field at the byte offset with zero or sign fill
   function automatic logic [31:0] expect_load(input logic [31:0] word, input int byte_off,
                                               input lsu_size_e size, input logic unsign);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[8*byte_off +: 8];
      h = word[8*byte_off +: 16];
      if (size == size_byte) return unsign ? 32'(b) : 32'($signed(b));
      if (size == size_half) return unsign ? 32'(h) : 32'($signed(h));
      return word;
   endfunction

   // ********************
   // Drivers
   // ********************

   task automatic drive_req(input logic is_load, input lsu_size_e size, input logic unsign,
                            input logic [31:0] base, input logic [OFFSET_W-1:0] off);
      lsu_valid  = 1'b1;
      lsu_load   = is_load;
      lsu_store  = ~is_load;
      lsu_size   = size;
      lsu_unsign = unsign;
      rs1        = base;
      offset     = off;
   endtask

   task automatic drive_idle();
      lsu_valid = 1'b0;
      lsu_load  = 1'b0;
      lsu_store = 1'b0;
   endtask

   task automatic flip_bits(input logic [DCCM_AW-1:0] idx, input logic [DCCM_W-1:0] mask);
      flip_idx  = idx;
      flip_mask = mask;
      flip_en   = 1'b1;
      @(negedge clk);
      flip_en   = 1'b0;
   endtask

   // Store data stays on the bus through dc1
   task automatic store_word(input logic [31:0] base, input logic [OFFSET_W-1:0] off,
                             input logic [DATA_W-1:0] data);
      logic [31:0] addr;
      addr = eff_addr(base, off);
      shadow[word_idx(addr)] = data;
      store_data = data;
      drive_req(1'b0, size_word, 1'b0, base, off);
      @(negedge clk);
      drive_idle();
      check_flag("dccm_wren", dccm_wren, 1'b1);
      check_flag("dccm_rden", dccm_rden, 1'b0);
      check_data("dccm_addr", 32'(dccm_addr), 32'(word_idx(addr)));
      check_data("dccm_wr_data", dccm_wr_data[DATA_W-1:0], data);
      check_flag("dccm_wr_data parity", ^dccm_wr_data, 1'b0);   // Even over all 39 bits
      repeat (2) @(negedge clk);
      check_flag("err_valid", err_valid, 1'b0);
      check_flag("result_valid", result_valid, 1'b0);
   endtask

   task automatic load_check(input logic [31:0] base, input logic [OFFSET_W-1:0] off,
                             input lsu_size_e size, input logic unsign,
                             input logic [DATA_W-1:0] exp, input logic exp_single);
      logic [31:0] addr;
      addr = eff_addr(base, off);
      drive_req(1'b1, size, unsign, base, off);
      @(negedge clk);
      drive_idle();
      check_flag("dccm_rden", dccm_rden, 1'b1);
      check_flag("dccm_wren", dccm_wren, 1'b0);
      check_data("dccm_addr", 32'(dccm_addr), 32'(word_idx(addr)));
      check_flag("lsu_idle", lsu_idle, 1'b0);
      @(negedge clk);
      check_flag("result_valid", result_valid, 1'b0);
      @(negedge clk);
      check_flag("result_valid", result_valid, 1'b1);   // Two cycles after the request
      check_flag("err_valid", err_valid, 1'b0);
      check_data("result", result, exp);
      check_flag("single_ecc_incr", single_ecc_incr, exp_single);
      @(negedge clk);
      check_flag("result_valid", result_valid, 1'b0);
   endtask

   task automatic fault_check(input logic is_load, input logic [31:0] base,
                              input logic [OFFSET_W-1:0] off, input lsu_size_e size,
                              input lsu_exc_e exp_exc);
      logic [31:0] addr;
      addr = eff_addr(base, off);
      store_data = $urandom;
      drive_req(is_load, size, 1'b0, base, off);
      @(negedge clk);
      drive_idle();
      check_flag("dccm_rden", dccm_rden, is_load && exp_exc == exc_ecc);   // ECC reads first
      check_flag("dccm_wren", dccm_wren, 1'b0);
      repeat (2) @(negedge clk);
      check_flag("err_valid", err_valid, 1'b1);
      check_flag("result_valid", result_valid, 1'b0);
      check_exc("err_type", err_type, exp_exc);
      check_data("err_addr", err_addr, addr);
      check_flag("err_store", err_store, ~is_load);
      @(negedge clk);
      check_flag("err_valid", err_valid, 1'b0);
   endtask

   // Flush while the op sits in dc1 (stage 1) or dc2 (stage 2)
   task automatic flush_op(input logic is_load, input logic [31:0] base,
                           input logic [OFFSET_W-1:0] off, input logic [DATA_W-1:0] data,
                           input int stage);
      store_data = data;
      drive_req(is_load, size_word, 1'b0, base, off);
      @(negedge clk);
      drive_idle();
      if (stage == 2) @(negedge clk);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      if (stage == 1) @(negedge clk);
      check_flag("result_valid", result_valid, 1'b0);
      check_flag("err_valid", err_valid, 1'b0);
      check_flag("lsu_idle", lsu_idle, 1'b1);
   endtask

   // ********************
   // Directed tests
   // ********************

   task automatic reload_stored_words();
      logic [31:0]         base;
      logic [OFFSET_W-1:0] off;
      for (int i = 0; i < 6; i++) begin
         base = DCCM_BASE + 32'(i) * 32'h104;
         off  = (i % 2 == 1) ? 12'hffc : 12'h008;   // Negative offset on odd steps
         store_word(base, off, $urandom);
      end
      store_word(DCCM_BASE + 32'hff0, 12'h00c, $urandom);   // Top word of the DCCM
      for (int i = 0; i < 6; i++) begin
         base = DCCM_BASE + 32'(i) * 32'h104;
         off  = (i % 2 == 1) ? 12'hffc : 12'h008;
         load_check(base, off, size_word, 1'b0, shadow[word_idx(eff_addr(base, off))], 1'b0);
      end
      load_check(DCCM_BASE + 32'hff0, 12'h00c, size_word, 1'b0,
                 shadow[word_idx(DCCM_BASE + 32'hffc)], 1'b0);
   endtask

   task automatic load_subwords();
      logic [31:0] pattern;
      pattern = 32'h80ff_7f01;   // Mix of positive and negative bytes and halves
      store_word(DCCM_BASE, 12'h040, pattern);
      for (int o = 0; o < 4; o++) begin
         for (int u = 0; u < 2; u++) begin
            load_check(DCCM_BASE, 12'(32'h40 + o), size_byte, u[0],
                       expect_load(pattern, o, size_byte, u[0]), 1'b0);
         end
      end
      for (int o = 0; o < 4; o += 2) begin
         for (int u = 0; u < 2; u++) begin
            load_check(DCCM_BASE, 12'(32'h40 + o), size_half, u[0],
                       expect_load(pattern, o, size_half, u[0]), 1'b0);
         end
      end
   endtask

   task automatic provoke_faults();
      fault_check(1'b1, DCCM_BASE, 12'hffc, size_word, exc_access);            // Below base
      fault_check(1'b1, DCCM_BASE + 32'hffc, 12'h004, size_byte, exc_access);  // Past 4 KB
      fault_check(1'b0, DCCM_BASE - 32'h100, 12'h000, size_word, exc_access);
      fault_check(1'b1, DCCM_BASE + 32'h40, 12'h001, size_half, exc_misaligned);
      fault_check(1'b1, DCCM_BASE + 32'h40, 12'h002, size_word, exc_misaligned);
      fault_check(1'b0, DCCM_BASE + 32'h41, 12'h000, size_word, exc_misaligned);
   endtask

   task automatic inject_ecc_errors();
      int                 bits [4];
      logic [DATA_W-1:0]  data;
      logic [DCCM_AW-1:0] idx;
      bits = '{5, 31, 35, 38};   // Two data bits, a check bit, the parity bit
      idx  = word_idx(DCCM_BASE + 32'h80);
      for (int i = 0; i < 4; i++) begin
         data = $urandom;
         store_word(DCCM_BASE, 12'h080, data);
         flip_bits(idx, DCCM_W'(1) << bits[i]);
         load_check(DCCM_BASE, 12'h080, size_word, 1'b0, data, 1'b1);
      end
      data = $urandom;
      store_word(DCCM_BASE, 12'h080, data);
      flip_bits(idx, (DCCM_W'(1) << 3) | (DCCM_W'(1) << 20));
      fault_check(1'b1, DCCM_BASE, 12'h080, size_word, exc_ecc);
   endtask

   task automatic flush_in_flight();
      logic [DATA_W-1:0] data;
      data = $urandom;
      store_word(DCCM_BASE, 12'h0c0, data);
      flush_op(1'b1, DCCM_BASE, 12'h0c0, '0, 1);
      flush_op(1'b1, DCCM_BASE, 12'h0c0, '0, 2);
      flush_op(1'b1, DCCM_BASE - 32'h4, 12'h000, '0, 2);   // Flushed faulting load leaves no error
      flush_op(1'b0, DCCM_BASE, 12'h0c0, ~data, 1);        // Store must not be written
      load_check(DCCM_BASE, 12'h0c0, size_word, 1'b0, data, 1'b0);
   endtask

   task automatic issue_back_to_back();
      logic [DATA_W-1:0] data;
      for (int i = 0; i < 3; i++) begin
         store_word(DCCM_BASE + 32'h300, 12'(4 * i), $urandom);
      end
      for (int i = 0; i < 3; i++) begin
         drive_req(1'b1, size_word, 1'b0, DCCM_BASE + 32'h300, 12'(4 * i));
         @(negedge clk);
      end
      drive_idle();
      for (int i = 0; i < 3; i++) begin
         check_flag("result_valid", result_valid, 1'b1);
         check_data("result", result, shadow[word_idx(DCCM_BASE + 32'h300 + 32'(4 * i))]);
         @(negedge clk);
      end
      check_flag("result_valid", result_valid, 1'b0);
      check_flag("lsu_idle", lsu_idle, 1'b1);

      // Load right behind a store to the same word
      data = $urandom;
      shadow[word_idx(DCCM_BASE + 32'h310)] = data;
      store_data = data;
      drive_req(1'b0, size_word, 1'b0, DCCM_BASE, 12'h310);
      @(negedge clk);
      drive_req(1'b1, size_word, 1'b0, DCCM_BASE, 12'h310);
      @(negedge clk);
      drive_idle();
      repeat (2) @(negedge clk);
      check_flag("result_valid", result_valid, 1'b1);
      check_data("result", result, data);
      @(negedge clk);
      check_flag("lsu_idle", lsu_idle, 1'b1);
   endtask

   initial begin
      void'($urandom(32'heee4));
      arst_n     = 1'b0;
      lsu_valid  = 1'b0;
      lsu_load   = 1'b0;
      lsu_store  = 1'b0;
      lsu_size   = size_word;
      lsu_unsign = 1'b0;
      rs1        = '0;
      offset     = '0;
      store_data = '0;
      flush      = 1'b0;
      flip_en    = 1'b0;
      flip_idx   = '0;
      flip_mask  = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      check_flag("dccm_rden", dccm_rden, 1'b0);
      check_flag("dccm_wren", dccm_wren, 1'b0);
      check_flag("result_valid", result_valid, 1'b0);
      check_flag("err_valid", err_valid, 1'b0);
      check_flag("single_ecc_incr", single_ecc_incr, 1'b0);
      check_flag("lsu_idle", lsu_idle, 1'b1);

      reload_stored_words();
      load_subwords();
      provoke_faults();
      inject_ecc_errors();
      flush_in_flight();
      issue_back_to_back();

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- lsu_top.f
verilog/lsu_pkg.sv
verilog/lsu_ecc.sv
verilog/lsu_addr_gen.sv
verilog/lsu_load_align.sv
verilog/lsu_ctl.sv
verilog/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= lsu_tb
FILELIST  ?= lsu_top.f

BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
